/* hdl/capture_control.sv */
/*
 * Capture sequencer
 * Fills the pre-trigger part, waits for the first trigger, fills the
 * post-trigger part and publishes the record origin for readout
 */

`timescale 1ns/1ps

module capture_control #(
    parameter int buffer_depth = 256
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              arm,
    input  scope_types_pkg::scope_cfg_t       cfg,
    input  scope_types_pkg::det_sample_t      det,
    output logic                              wr_en,
    output logic                              clear,
    input  logic [$clog2(buffer_depth)-1:0]   wr_addr,
    output scope_types_pkg::capture_state_t   state,
    output logic [$clog2(buffer_depth)-1:0]   start_addr
);

    import scope_types_pkg::*;

    localparam int addr_w = $clog2(buffer_depth);
    localparam logic [addr_w-1:0] last_index = addr_w'(buffer_depth - 1);

    logic [addr_w-1:0] tp_eff;
    logic [addr_w-1:0] tp_lat;
    logic [addr_w-1:0] post_len;
    logic [addr_w-1:0] count;
    logic [addr_w-1:0] trig_addr;
    logic start;

    // A trigger point beyond the buffer leaves one slot for the trigger itself
    assign tp_eff = (cfg.trigger_point >= buffer_depth) ? last_index :
                    cfg.trigger_point[addr_w-1:0];

    // Samples still owed after the trigger sample
    assign post_len = last_index - tp_lat;

    // Arm only counts while no capture is running
    assign start = arm && ((state == idle) || (state == done));
    assign clear = start;

    assign wr_en = (state == pretrig) || (state == armed) || (state == posttrig);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= idle;
            count <= '0;
            tp_lat <= '0;
            trig_addr <= '0;
        end else begin
            case (state)
                idle, done: begin
                    if (start) begin
                        // The trigger point is frozen for the whole capture
                        tp_lat <= tp_eff;
                        count <= '0;
                        state <= (tp_eff == '0) ? armed : pretrig;
                    end
                end
                pretrig: begin
                    // Triggers seen here are ignored on purpose
                    if (det.valid) begin
                        if (count == tp_lat - 1'b1) begin
                            count <= '0;
                            state <= armed;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                armed: begin
                    // The buffer keeps rolling until the first trigger sample
                    if (det.valid && det.trigger) begin
                        trig_addr <= wr_addr;
                        count <= '0;
                        state <= (post_len == '0) ? done : posttrig;
                    end
                end
                posttrig: begin
                    if (det.valid) begin
                        if (count == post_len - 1'b1) begin
                            state <= done;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Index 0 of the record lies trigger_point slots before the trigger
    assign start_addr = trig_addr - tp_lat;

endmodule

/* hdl/sample_buffer.sv */
/*
 * Capture sample memory
 * Circular store of the trigger channel with a wrapping write pointer
 * and a one-cycle registered read port
 */

`timescale 1ns/1ps

module sample_buffer #(
    parameter int buffer_depth = 256
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              clear,
    input  logic                              wr_en,
    input  scope_types_pkg::det_sample_t      det,
    output logic [$clog2(buffer_depth)-1:0]   wr_addr,
    input  logic [$clog2(buffer_depth)-1:0]   rd_addr,
    output scope_types_pkg::sample_t          rd_data
);

    import scope_types_pkg::*;

    localparam int addr_w = $clog2(buffer_depth);

    sample_t mem [buffer_depth];
    logic [addr_w-1:0] wr_ptr;
    logic write;

    // Only samples the detector marked valid enter the record
    assign write = wr_en && det.valid;

    // The pointer wraps by overflow since the depth is a power of two
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (write) mem[wr_ptr] <= det.data;
    end

    // Read port is free running; the bus waits one cycle for it
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

    // Control snoops the pointer to learn where the trigger sample lands
    assign wr_addr = wr_ptr;

endmodule

/* hdl/scope_bus_pkg.sv */
/*
 * Register bus definitions
 * Request bundle of the four-phase req/ack bus and the register map
 */

package scope_bus_pkg;

    typedef logic [9:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // Held stable by the master for as long as req is high
    typedef struct packed {
        logic      write;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    // Writing 1 to bit 0 arms a capture
    localparam bus_addr_t reg_control = 10'h000;

    localparam bus_addr_t reg_mode = 10'h001;
    localparam bus_addr_t reg_level = 10'h002;
    localparam bus_addr_t reg_channel = 10'h003;
    localparam bus_addr_t reg_trigger_point = 10'h004;

    // Read only status word with state in bits 2:0 and done in bit 8
    localparam bus_addr_t reg_status = 10'h005;

    // Record index i of the captured buffer is read at buffer_base + i
    localparam bus_addr_t buffer_base = 10'h100;

endpackage

/* hdl/scope_registers.sv */
/*
 * Scope register block
 * Four-phase bus slave holding the trigger configuration, issuing the
 * arm pulse, reporting status and reading the capture record in time order
 */

`timescale 1ns/1ps

module scope_registers #(
    parameter int n_channels = 6,
    parameter int buffer_depth = 256
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  scope_bus_pkg::bus_req_t           bus_req,
    input  logic                              req,
    output logic                              ack,
    output scope_bus_pkg::bus_data_t          rdata,
    input  scope_types_pkg::capture_state_t   state,
    input  logic [$clog2(buffer_depth)-1:0]   start_addr,
    output scope_types_pkg::scope_cfg_t       cfg,
    output logic                              arm,
    output logic [$clog2(buffer_depth)-1:0]   rd_addr,
    input  scope_types_pkg::sample_t          rd_data
);

    import scope_types_pkg::*;
    import scope_bus_pkg::*;

    localparam int addr_w = $clog2(buffer_depth);

    // Buffer reads spend one extra cycle in fetch for the memory latency
    typedef enum logic [1:0] {
        bus_wait,
        bus_fetch,
        bus_hold
    } bus_state_t;

    bus_state_t bus_state;
    scope_cfg_t cfg_q;
    logic cfg_open;
    logic in_window;
    bus_data_t reg_value;
    bus_data_t status_word;

    // Configuration is only writable while no capture is running
    assign cfg_open = (state == idle) || (state == done);

    assign in_window = (bus_req.addr >= buffer_base) &&
                       (bus_req.addr < buffer_base + buffer_depth);

    // Record index 0 sits at start_addr, the sum wraps modulo the depth
    assign rd_addr = start_addr + addr_w'(bus_req.addr - buffer_base);

    // Channel count in bits 23:16 lets software size its channel field
    assign status_word = {8'h00, 8'(n_channels), 7'b0, (state == done), 5'b0, state};

    always_comb begin
        reg_value = '0;
        case (bus_req.addr)
            reg_mode:          reg_value = bus_data_t'(cfg_q.mode);
            reg_level:         reg_value = bus_data_t'(cfg_q.level);
            reg_channel:       reg_value = bus_data_t'(cfg_q.channel);
            reg_trigger_point: reg_value = bus_data_t'(cfg_q.trigger_point);
            reg_status:        reg_value = status_word;
            default:           reg_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bus_state <= bus_wait;
            arm <= 1'b0;
            cfg_q <= '{mode: rising, level: '0, channel: '0, trigger_point: '0};
        end else begin
            arm <= 1'b0;
            case (bus_state)
                bus_wait: begin
                    if (req) begin
                        if (!bus_req.write && in_window) begin
                            bus_state <= bus_fetch;
                        end else begin
                            bus_state <= bus_hold;
                        end
                        // Register writes take effect on the edge that raises ack
                        if (bus_req.write) begin
                            case (bus_req.addr)
                                reg_control: arm <= bus_req.wdata[0] && cfg_open;
                                reg_mode: begin
                                    if (cfg_open) begin
                                        cfg_q.mode <= trig_mode_t'(bus_req.wdata[1:0]);
                                    end
                                end
                                reg_level: begin
                                    if (cfg_open) cfg_q.level <= bus_req.wdata[15:0];
                                end
                                reg_channel: begin
                                    if (cfg_open) cfg_q.channel <= bus_req.wdata[7:0];
                                end
                                reg_trigger_point: begin
                                    if (cfg_open) cfg_q.trigger_point <= bus_req.wdata[15:0];
                                end
                                default: ;
                            endcase
                        end
                    end
                end
                // rd_data now holds the word addressed in the previous cycle
                bus_fetch: bus_state <= bus_hold;
                bus_hold: begin
                    if (!req) bus_state <= bus_wait;
                end
                default: bus_state <= bus_wait;
            endcase
        end
    end

    // Read data is captured once per access and then held while ack is high
    always_ff @(posedge clock) begin
        if (bus_state == bus_wait && req && !bus_req.write && !in_window) begin
            rdata <= reg_value;
        end else if (bus_state == bus_fetch) begin
            rdata <= bus_data_t'(rd_data);
        end
    end

    assign ack = (bus_state == bus_hold);
    assign cfg = cfg_q;

endmodule

/* hdl/scope_top.sv */
/*
 * Oscilloscope trigger and capture core
 * Joins the register block, trigger detector, sample memory and sequencer
 */

`timescale 1ns/1ps

module scope_top #(
    parameter int n_channels = 6,
    parameter int buffer_depth = 256
) (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  scope_types_pkg::sample_t [n_channels-1:0]   samples,
    input  logic                                        sample_valid,
    input  scope_bus_pkg::bus_req_t                     bus_req,
    input  logic                                        req,
    output logic                                        ack,
    output scope_bus_pkg::bus_data_t                    rdata,
    output logic                                        trigger,
    output logic                                        capture_done
);

    import scope_types_pkg::*;

    localparam int addr_w = $clog2(buffer_depth);

    scope_cfg_t cfg;
    logic arm;
    capture_state_t state;
    logic [addr_w-1:0] start_addr;
    logic [addr_w-1:0] rd_addr;
    logic [addr_w-1:0] wr_addr;
    sample_t rd_data;
    det_sample_t det;
    logic wr_en;
    logic clear;

    scope_registers #(
        .n_channels  (n_channels),
        .buffer_depth(buffer_depth)
    ) u_scope_registers (
        .clock     (clock),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .req       (req),
        .ack       (ack),
        .rdata     (rdata),
        .state     (state),
        .start_addr(start_addr),
        .cfg       (cfg),
        .arm       (arm),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    trigger_detector #(
        .n_channels(n_channels)
    ) u_trigger_detector (
        .clock       (clock),
        .rst_n       (rst_n),
        .arm         (arm),
        .samples     (samples),
        .sample_valid(sample_valid),
        .cfg         (cfg),
        .det         (det)
    );

    sample_buffer #(
        .buffer_depth(buffer_depth)
    ) u_sample_buffer (
        .clock  (clock),
        .rst_n  (rst_n),
        .clear  (clear),
        .wr_en  (wr_en),
        .det    (det),
        .wr_addr(wr_addr),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    capture_control #(
        .buffer_depth(buffer_depth)
    ) u_capture_control (
        .clock     (clock),
        .rst_n     (rst_n),
        .arm       (arm),
        .cfg       (cfg),
        .det       (det),
        .wr_en     (wr_en),
        .clear     (clear),
        .wr_addr   (wr_addr),
        .state     (state),
        .start_addr(start_addr)
    );

    // Every crossing is reported, whatever the capture state
    assign trigger = det.valid && det.trigger;
    assign capture_done = (state == done);

endmodule

/* hdl/scope_types_pkg.sv */
/*
 * Scope datapath types
 * Sample and level widths, trigger modes, the configuration bundle,
 * the detector output bundle and the capture state encoding
 */

package scope_types_pkg;

    // One ADC sample, treated as unsigned everywhere
    typedef logic [15:0] sample_t;

    // Trigger threshold, compared unsigned against sample_t
    typedef logic [15:0] level_t;

    // Index of the channel that drives the trigger
    typedef logic [7:0] channel_t;

    // Number of samples kept ahead of the trigger sample
    typedef logic [15:0] trig_point_t;

    // Edge selection of the trigger, where encoding 3 is unused and never fires
    typedef enum logic [1:0] {
        rising  = 2'd0,
        falling = 2'd1,
        both    = 2'd2
    } trig_mode_t;

    // Configuration driven by the register block
    typedef struct packed {
        trig_mode_t  mode;
        level_t      level;
        channel_t    channel;
        trig_point_t trigger_point;
    } scope_cfg_t;

    // Registered output of the detector, one entry per accepted sample
    typedef struct packed {
        logic    valid;
        sample_t data;
        logic    trigger;
    } det_sample_t;

    // Capture sequencer states, also visible in the status register
    typedef enum logic [2:0] {
        idle     = 3'd0,
        pretrig  = 3'd1,
        armed    = 3'd2,
        posttrig = 3'd3,
        done     = 3'd4
    } capture_state_t;

endpackage

/* hdl/trigger_detector.sv */
/*
 * Trigger detector
 * Picks the configured channel and flags level crossings against the
 * previously accepted sample of that channel
 */

`timescale 1ns/1ps

module trigger_detector #(
    parameter int n_channels = 6
) (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic                                        arm,
    input  scope_types_pkg::sample_t [n_channels-1:0]   samples,
    input  logic                                        sample_valid,
    input  scope_types_pkg::scope_cfg_t                 cfg,
    output scope_types_pkg::det_sample_t                det
);

    import scope_types_pkg::*;

    sample_t selected;
    sample_t prev_data;
    sample_t det_data;
    logic prev_valid;
    logic cross_up;
    logic cross_down;
    logic crossing;
    logic det_valid;
    logic det_trigger;

    // A channel index past the last input falls back to channel 0
    always_comb begin
        if (cfg.channel < n_channels) begin
            selected = samples[cfg.channel];
        end else begin
            selected = samples[0];
        end
    end

    // Rising means leaving the band at or below the level, falling means entering it
    assign cross_up = (prev_data <= cfg.level) && (selected > cfg.level);
    assign cross_down = (prev_data > cfg.level) && (selected <= cfg.level);

    always_comb begin
        case (cfg.mode)
            rising:  crossing = cross_up;
            falling: crossing = cross_down;
            both:    crossing = cross_up || cross_down;
            default: crossing = 1'b0;
        endcase
    end

    // Arm forgets the history of the selected channel, while a sample
    // arriving together with arm becomes the new reference
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            prev_valid <= 1'b0;
        end else if (sample_valid) begin
            prev_valid <= 1'b1;
        end else if (arm) begin
            prev_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (sample_valid) prev_data <= selected;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            det_valid <= 1'b0;
            det_trigger <= 1'b0;
        end else begin
            det_valid <= sample_valid;
            // The sample seen together with arm has no usable predecessor
            det_trigger <= sample_valid && prev_valid && !arm && crossing;
        end
    end

    always_ff @(posedge clock) begin
        det_data <= selected;
    end

    assign det = '{valid: det_valid, data: det_data, trigger: det_trigger};

endmodule

/* src.f */
hdl/scope_types_pkg.sv
hdl/scope_bus_pkg.sv
hdl/scope_registers.sv
hdl/trigger_detector.sv
hdl/sample_buffer.sv
hdl/capture_control.sv
hdl/scope_top.sv
tests/scope_properties.sv
tests/scope_tb.sv

/* tests/scope_properties.sv */
/*
 * Protocol and output checks for the scope core
 * Bound into scope_top, watches the bus handshake and the capture outputs
 */

`timescale 1ns/1ps

module scope_properties (
    input logic                              clock,
    input logic                              rst_n,
    input logic                              req,
    input logic                              ack,
    input scope_bus_pkg::bus_data_t          rdata,
    input logic                              sample_valid,
    input logic                              trigger,
    input logic                              capture_done,
    input scope_types_pkg::capture_state_t   state
);

    import scope_types_pkg::*;

    // Running count of failed assertions
    int fail_count = 0;

    // With neither req nor ack, the slave stays quiet
    ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
        !req && !ack |=> !ack)
        else begin
            $error("ack rose without req");
            fail_count++;
        end

    // Phase four of the handshake
    ack_drops: assert property (@(posedge clock) disable iff (!rst_n)
        ack && !req |=> !ack)
        else begin
            $error("ack did not fall after req went low");
            fail_count++;
        end

    rdata_held: assert property (@(posedge clock) disable iff (!rst_n)
        ack |=> !ack || $stable(rdata))
        else begin
            $error("rdata changed while ack was high");
            fail_count++;
        end

    // A trigger always belongs to a sample taken in the previous cycle
    trigger_needs_sample: assert property (@(posedge clock) disable iff (!rst_n)
        !sample_valid |=> !trigger)
        else begin
            $error("trigger without a sample in the cycle before");
            fail_count++;
        end

    done_low_after_reset: assert property (@(posedge clock)
        !rst_n |=> !capture_done)
        else begin
            $error("capture_done high right after reset");
            fail_count++;
        end

    // capture_done only rises when a running capture writes its last sample
    done_after_capture: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(capture_done) |-> ($past(state) == posttrig) || ($past(state) == armed))
        else begin
            $error("capture_done rose without a capture finishing");
            fail_count++;
        end

endmodule

bind scope_top scope_properties u_scope_properties (
    .clock       (clock),
    .rst_n       (rst_n),
    .req         (req),
    .ack         (ack),
    .rdata       (rdata),
    .sample_valid(sample_valid),
    .trigger     (trigger),
    .capture_done(capture_done),
    .state       (state)
);

/* tests/scope_tb.sv */
/*
 * Testbench for the scope trigger and capture core
 * Drives the four-phase bus and a shaped sample stream, predicts
 * triggers and capture records from the crossing and capture rules
 */

`timescale 1ns/1ps

module scope_tb;

    import scope_types_pkg::*;
    import scope_bus_pkg::*;

    localparam int n_ch = 6;
    localparam int depth = 64;
    localparam int tp = 16;
    localparam int clock_period = 100;
    localparam int bus_limit = 8;
    localparam int stream_cycles = 200;
    localparam int capture_limit = 400;
    // Every access may take up to two full waits, each capture up to its limit
    localparam int bus_ops = 2 * depth + 48;
    localparam int watchdog_cycles = 8 + bus_ops * (2 * bus_limit + 1) + stream_cycles +
                                     2 * (capture_limit + 4) + 500;

    logic clock;
    logic rst_n;
    sample_t [n_ch-1:0] samples;
    logic sample_valid;
    bus_req_t bus_req;
    logic req;
    logic ack;
    bus_data_t rdata;
    logic trigger;
    logic capture_done;

    // Reference model of the detector and the capture record
    trig_mode_t model_mode;
    level_t model_level;
    int model_channel;
    sample_t model_prev;
    logic model_prev_valid;
    logic expect_trig;
    int trig_total;
    int step;
    logic [31:0] lcg_state;
    int cap_count;
    int trig_index;
    int pre_cross;
    sample_t cap_samples[$];

    scope_top #(
        .n_channels  (n_ch),
        .buffer_depth(depth)
    ) u_scope_top (
        .clock       (clock),
        .rst_n       (rst_n),
        .samples     (samples),
        .sample_valid(sample_valid),
        .bus_req     (bus_req),
        .req         (req),
        .ack         (ack),
        .rdata       (rdata),
        .trigger     (trigger),
        .capture_done(capture_done)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_cycles * clock_period);
        stop_with_failure("watchdog expired before the test sequence completed");
    end

    // Any failed bound assertion ends the run at once
    initial begin
        wait (u_scope_top.u_scope_properties.fail_count != 0);
        stop_with_failure("bound protocol assertions reported errors");
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_with_failure($sformatf("[FAIL] %0t %s expected 0x%0h actual 0x%0h",
                                        $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Rising leaves the band at or below the level and falling re-enters it
    function automatic logic crossing_expected(input trig_mode_t mode, input sample_t prev,
                                               input sample_t cur, input level_t level);
        logic up;
        logic down;
        up = (prev <= level) && (cur > level);
        down = (prev > level) && (cur <= level);
        case (mode)
            rising:  return up;
            falling: return down;
            both:    return up || down;
            default: return 1'b0;
        endcase
    endfunction

    // Drives one valid sample and books it in the model
    task automatic apply_sample(input sample_t [n_ch-1:0] vec);
        sample_t cur;
        logic fire;
        cur = vec[model_channel];
        fire = model_prev_valid && crossing_expected(model_mode, model_prev, cur, model_level);
        model_prev = cur;
        model_prev_valid = 1'b1;
        if (fire) trig_total++;
        cap_samples.push_back(cur);
        // Crossings inside the pre-trigger part never start the post-trigger part
        if (cap_count < tp) begin
            if (fire) pre_cross++;
        end else if (trig_index < 0 && fire) begin
            trig_index = cap_count;
        end
        cap_count++;
        samples = vec;
        sample_valid = 1'b1;
        expect_trig = fire;
    endtask

    task automatic drive_next_sample();
        sample_t [n_ch-1:0] vec;
        lcg_state = lcg_next(lcg_state);
        // About one cycle in eight carries no sample
        if (lcg_state[31:29] == 3'd0) begin
            sample_valid = 1'b0;
            expect_trig = 1'b0;
        end else begin
            for (int c = 0; c < n_ch; c++) begin
                if (c == model_channel) begin
                    // Sawtooth over eight samples with a little noise close to the level
                    vec[c] = model_level - 16'd48 + 16'(step % 8) * 16'd14 +
                             16'(lcg_state[20:18]);
                end else begin
                    // Square steps shifted per channel, so they cross where the ramp does not
                    vec[c] = (((step + c * 3) % 6) < 3) ? model_level + 16'd200 :
                                                          model_level - 16'd200;
                end
            end
            step++;
            apply_sample(vec);
        end
    endtask

    // Trigger for the sample of the previous cycle is checked on every falling edge
    task automatic run_stream(input int max_cycles, input bit until_done);
        int cycle;
        bit finished;
        cycle = 0;
        finished = 1'b0;
        while (cycle < max_cycles && !finished) begin
            @(negedge clock);
            check_value("trigger", expect_trig, trigger);
            if (until_done && capture_done) begin
                finished = 1'b1;
                assert (trig_index >= 0 && cap_count >= trig_index + depth - tp &&
                        cap_count <= trig_index + depth - tp + 1)
                    else stop_with_failure("capture_done did not follow the last sample");
                sample_valid = 1'b0;
                expect_trig = 1'b0;
            end else begin
                drive_next_sample();
            end
            cycle++;
        end
        @(negedge clock);
        check_value("trigger", expect_trig, trigger);
        sample_valid = 1'b0;
        expect_trig = 1'b0;
        if (until_done && !finished) begin
            stop_with_failure("capture did not finish within the stream limit");
        end
    endtask

    task automatic bus_access(input logic write, input bus_addr_t addr,
                              input bus_data_t wdata, output bus_data_t data);
        int waited;
        int latency;
        // Buffer reads pay one extra cycle for the registered memory
        latency = (!write && addr >= buffer_base) ? 2 : 1;
        @(negedge clock);
        bus_req = '{write: write, addr: addr, wdata: wdata};
        req = 1'b1;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!ack && waited < bus_limit);
        if (!ack) stop_with_failure("bus access received no ack");
        check_value("ack latency", 32'(latency), 32'(waited));
        data = rdata;
        req = 1'b0;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (ack && waited < bus_limit);
        if (ack) stop_with_failure("ack stayed high after req was dropped");
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t wdata);
        bus_data_t unused;
        bus_access(1'b1, addr, wdata, unused);
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        bus_access(1'b0, addr, '0, data);
    endtask

    task automatic configure(input trig_mode_t mode, input level_t level, input int channel);
        bus_write(reg_mode, 32'(mode));
        bus_write(reg_level, 32'(level));
        bus_write(reg_channel, 32'(channel));
        bus_write(reg_trigger_point, 32'(tp));
        model_mode = mode;
        model_level = level;
        model_channel = channel;
    endtask

    task automatic check_config();
        bus_data_t data;
        bus_read(reg_mode, data);
        check_value("mode", 32'(model_mode), data);
        bus_read(reg_level, data);
        check_value("level", 32'(model_level), data);
        bus_read(reg_channel, data);
        check_value("channel", 32'(model_channel), data);
        bus_read(reg_trigger_point, data);
        check_value("trigger_point", 32'(tp), data);
    endtask

    task automatic check_status(input capture_state_t state, input logic is_done);
        bus_data_t data;
        bus_read(reg_status, data);
        check_value("status.state", 32'(state), 32'(data[2:0]));
        check_value("status.done", 32'(is_done), 32'(data[8]));
    endtask

    // A high sample right before arm makes the first captured sample a falling edge
    task automatic arm_capture();
        sample_t [n_ch-1:0] high;
        high = {n_ch{sample_t'(model_level + 16'd100)}};
        @(negedge clock);
        apply_sample(high);
        @(negedge clock);
        check_value("trigger", expect_trig, trigger);
        sample_valid = 1'b0;
        expect_trig = 1'b0;
        bus_write(reg_control, 32'h1);
        model_prev_valid = 1'b0;
        cap_count = 0;
        trig_index = -1;
        pre_cross = 0;
        cap_samples.delete();
        step = 0;
        trig_total = 0;
    endtask

    // Record index i must hold the i-th sample counted from tp before the trigger
    task automatic check_record();
        bus_data_t data;
        int first;
        assert (pre_cross > 0)
            else stop_with_failure("no crossing fell inside the pre-trigger part");
        assert (trig_total > 0)
            else stop_with_failure("no crossing was driven during the capture");
        first = trig_index - tp;
        for (int i = 0; i < depth; i++) begin
            bus_read(buffer_base + bus_addr_t'(i), data);
            check_value($sformatf("record[%0d]", i), 32'(cap_samples[first + i]), data);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        samples = '0;
        sample_valid = 1'b0;
        bus_req = '0;
        req = 1'b0;
        lcg_state = 32'd56;
        model_mode = rising;
        model_level = '0;
        model_channel = 0;
        model_prev = '0;
        model_prev_valid = 1'b0;
        expect_trig = 1'b0;
        trig_total = 0;
        step = 0;
        cap_count = 0;
        trig_index = -1;
        pre_cross = 0;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;

        // Registers after reset, then configuration round trip
        check_status(idle, 1'b0);
        configure(rising, 16'h4000, 2);
        check_config();

        // Free running detection without a capture
        run_stream(stream_cycles, 1'b0);
        assert (trig_total > 0) else stop_with_failure("no rising crossing was driven");

        // Falling capture, with blocked writes and a blocked arm halfway through
        configure(falling, 16'h4000, 2);
        arm_capture();
        run_stream(20, 1'b0);
        bus_write(reg_mode, 32'(both));
        bus_write(reg_level, 32'h1234);
        bus_write(reg_channel, 32'd5);
        bus_write(reg_trigger_point, 32'd3);
        bus_write(reg_control, 32'h1);
        check_config();
        run_stream(capture_limit, 1'b1);
        check_status(done, 1'b1);
        check_record();

        // New arm after done restarts the capture on another channel
        configure(both, 16'h2000, 4);
        arm_capture();
        run_stream(capture_limit, 1'b1);
        check_status(done, 1'b1);
        check_record();

        if (u_scope_top.u_scope_properties.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_with_failure("bound protocol assertions reported errors");
        end
    end

endmodule
